/* logic/sparc_defines.svh */
`ifndef SPARC_DEFINES_SVH
`define SPARC_DEFINES_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define DISP22_W    22
`define SIMM13_W    13
`define RESET_PC    32'h0000_0000
`define PC_STEP     32'd4

// Instruction word fields
`define OP_MSB      31
`define OP_LSB      30
`define RD_MSB      29
`define RD_LSB      25
`define ANNUL_BIT   29
`define COND_MSB    28
`define COND_LSB    25
`define OP2_MSB     24
`define OP2_LSB     22
`define OP3_MSB     24
`define OP3_LSB     19
`define RS1_MSB     18
`define RS1_LSB     14
`define IMM_BIT     13
`define RS2_MSB     4
`define RS2_LSB     0
`define SETHI_SHIFT 10

`endif

/* logic/sparcPkg.sv */
`include "sparc_defines.svh"

package sparcPkg;

    typedef logic [`WORD_W-1:0]     wordT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    typedef enum logic [1:0] {
        branchSethi = 2'b00,
        call        = 2'b01,
        arith       = 2'b10,
        memory      = 2'b11
    } opFieldT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluAddc  = 4'd1,
        aluSub   = 4'd2,
        aluSubc  = 4'd3,
        aluAnd   = 4'd4,
        aluOr    = 4'd5,
        aluXor   = 4'd6,
        aluXnor  = 4'd7,
        aluAndn  = 4'd8,
        aluOrn   = 4'd9,
        aluSll   = 4'd10,
        aluSrl   = 4'd11,
        aluSra   = 4'd12,
        aluPassB = 4'd14
    } aluOpT;

    // Bicc cond field, upper half is the complement of the lower half
    typedef enum logic [3:0] {
        condNever, condEq, condLe, condLt, condLeu, condCs, condNeg, condVs,
        condAlways, condNe, condGt, condGe, condGu, condCc, condPos, condVc
    } condT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flagsT;

    typedef enum logic [1:0] {
        fromFile,
        fromEx,
        fromWb
    } fwdSelT;

endpackage

/* logic/instructionDecoder.sv */
`timescale 1ns/10ps
`include "sparc_defines.svh"

module instructionDecoder (
    input  sparcPkg::wordT    instr,
    output sparcPkg::aluOpT   aluOp,
    output sparcPkg::regAddrT rs1,
    output sparcPkg::regAddrT rs2,
    output sparcPkg::regAddrT rd,
    output logic              useImm,
    output sparcPkg::wordT    immValue,
    output logic              regWrite,
    output logic              setCc,
    output logic              isBranch,
    output logic              annul,
    output sparcPkg::condT    cond,
    output sparcPkg::wordT    disp
);

    sparcPkg::opFieldT    op;
    logic [2:0]           op2;
    logic [5:0]           op3;
    logic [`SIMM13_W-1:0] simm13;
    logic [`DISP22_W-1:0] imm22;

    assign op     = sparcPkg::opFieldT'(instr[`OP_MSB:`OP_LSB]);
    assign op2    = instr[`OP2_MSB:`OP2_LSB];
    assign op3    = instr[`OP3_MSB:`OP3_LSB];
    assign simm13 = instr[`SIMM13_W-1:0];
    assign imm22  = instr[`DISP22_W-1:0];

    assign rs1  = instr[`RS1_MSB:`RS1_LSB];
    assign rs2  = instr[`RS2_MSB:`RS2_LSB];
    assign rd   = instr[`RD_MSB:`RD_LSB];
    assign disp = {{(`WORD_W-`DISP22_W){imm22[`DISP22_W-1]}}, imm22}; // Word displacement

    always_comb
    begin
        aluOp    = sparcPkg::aluAdd;
        useImm   = 1'b0;
        immValue = {{(`WORD_W-`SIMM13_W){simm13[`SIMM13_W-1]}}, simm13};
        regWrite = 1'b0;
        setCc    = 1'b0;
        isBranch = 1'b0;
        annul    = 1'b0;
        cond     = sparcPkg::condNever;
        case (op)
            sparcPkg::branchSethi:
            begin
                if (op2 == 3'b100)
                begin
                    aluOp    = sparcPkg::aluPassB; // SETHI
                    useImm   = 1'b1;
                    immValue = {{(`WORD_W-`DISP22_W){1'b0}}, imm22} << `SETHI_SHIFT;
                    regWrite = 1'b1;
                end
                else if (op2 == 3'b010)
                begin
                    isBranch = 1'b1; // Bicc
                    annul    = instr[`ANNUL_BIT];
                    cond     = sparcPkg::condT'(instr[`COND_MSB:`COND_LSB]);
                end
            end
            sparcPkg::arith:
            begin
                useImm   = instr[`IMM_BIT];
                regWrite = 1'b1;
                if (op3[5] == 1'b0)
                begin
                    case (op3[3:0])
                        4'd0:    aluOp = sparcPkg::aluAdd;
                        4'd8:    aluOp = sparcPkg::aluAddc;
                        4'd4:    aluOp = sparcPkg::aluSub;
                        4'd12:   aluOp = sparcPkg::aluSubc;
                        4'd1:    aluOp = sparcPkg::aluAnd;
                        4'd2:    aluOp = sparcPkg::aluOr;
                        4'd3:    aluOp = sparcPkg::aluXor;
                        4'd5:    aluOp = sparcPkg::aluAndn;
                        4'd6:    aluOp = sparcPkg::aluOrn;
                        4'd7:    aluOp = sparcPkg::aluXnor;
                        default: regWrite = 1'b0; // Unsupported op3
                    endcase
                    setCc = op3[4] & regWrite; // cc variants
                end
                else if (op3[5:4] == 2'b10)
                begin
                    case (op3[3:0])
                        4'd5:    aluOp = sparcPkg::aluSll;
                        4'd6:    aluOp = sparcPkg::aluSrl;
                        4'd7:    aluOp = sparcPkg::aluSra;
                        default: regWrite = 1'b0;
                    endcase
                end
                else
                begin
                    regWrite = 1'b0; // JMPL and friends dropped
                end
            end
            default: ; // Call and memory words act as nops
        endcase
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/10ps
`include "sparc_defines.svh"

module registerFile (
    input  logic              Clk,
    input  sparcPkg::regAddrT readA,
    input  sparcPkg::regAddrT readB,
    output sparcPkg::wordT    dataA,
    output sparcPkg::wordT    dataB,
    input  logic              writeEn,
    input  sparcPkg::regAddrT writeAddr,
    input  sparcPkg::wordT    writeData
);

    sparcPkg::wordT regs [`NUM_REGS];

    always_ff @(posedge Clk)
    begin
        if (writeEn && (writeAddr != '0))
        begin
            regs[writeAddr] <= writeData; // r0 never written
        end
    end

    // r0 is hardwired to zero
    assign dataA = (readA == '0) ? '0 : regs[readA];
    assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

/* logic/alu.sv */
`timescale 1ns/10ps
`include "sparc_defines.svh"

module alu (
    input  sparcPkg::aluOpT op,
    input  sparcPkg::wordT  a,
    input  sparcPkg::wordT  b,
    input  logic            carryIn,
    output sparcPkg::wordT  result,
    output sparcPkg::flagsT flags
);

    logic [`WORD_W:0] sum;      // Extra bit holds carry or borrow
    logic [`WORD_W:0] carryExt;
    logic [4:0]       shamt;
    logic             overflow;
    logic             carryOut;

    assign shamt    = b[4:0];
    assign carryExt = {{`WORD_W{1'b0}},
                       carryIn & ((op == sparcPkg::aluAddc) || (op == sparcPkg::aluSubc))};

    always_comb
    begin
        sum      = '0;
        result   = '0;
        overflow = 1'b0;
        carryOut = 1'b0;
        case (op)
            sparcPkg::aluAdd, sparcPkg::aluAddc:
            begin
                sum      = {1'b0, a} + {1'b0, b} + carryExt;
                result   = sum[`WORD_W-1:0];
                carryOut = sum[`WORD_W];
                overflow = (a[`WORD_W-1] == b[`WORD_W-1])
                           && (result[`WORD_W-1] != a[`WORD_W-1]);
            end
            sparcPkg::aluSub, sparcPkg::aluSubc:
            begin
                sum      = {1'b0, a} - {1'b0, b} - carryExt;
                result   = sum[`WORD_W-1:0];
                carryOut = sum[`WORD_W]; // Borrow
                overflow = (a[`WORD_W-1] != b[`WORD_W-1])
                           && (result[`WORD_W-1] != a[`WORD_W-1]);
            end
            sparcPkg::aluAnd:   result = a & b;
            sparcPkg::aluOr:    result = a | b;
            sparcPkg::aluXor:   result = a ^ b;
            sparcPkg::aluXnor:  result = ~(a ^ b);
            sparcPkg::aluAndn:  result = a & ~b;
            sparcPkg::aluOrn:   result = a | ~b;
            sparcPkg::aluSll:   result = a << shamt;
            sparcPkg::aluSrl:   result = a >> shamt;
            sparcPkg::aluSra:   result = $signed(a) >>> shamt;
            sparcPkg::aluPassB: result = b; // SETHI path
            default:            result = '0;
        endcase
    end

    assign flags.n = result[`WORD_W-1];
    assign flags.z = (result == '0);
    assign flags.v = overflow;
    assign flags.c = carryOut;

endmodule

/* logic/branchCondition.sv */
`timescale 1ns/10ps

module branchCondition (
    input  logic            Clk,
    input  logic            reset,
    input  sparcPkg::flagsT exFlags,
    input  logic            exSetCc,
    input  sparcPkg::condT  cond,
    input  logic            isBranch,
    output logic            carry,
    output logic            taken
);

    sparcPkg::flagsT psr;
    sparcPkg::flagsT selFlags;
    logic            condTrue;

    always_ff @(posedge Clk)
    begin
        if (reset)
            psr <= '0;
        else if (exSetCc)
            psr <= exFlags;
    end

    assign carry = psr.c; // Feeds addx and subx

    // A cc instruction in EX is one edge ahead of the PSR
    assign selFlags = exSetCc ? exFlags : psr;

    always_comb
    begin
        case (cond)
            sparcPkg::condNever:  condTrue = 1'b0;
            sparcPkg::condEq:     condTrue = selFlags.z;
            sparcPkg::condLe:     condTrue = selFlags.z | (selFlags.n ^ selFlags.v);
            sparcPkg::condLt:     condTrue = selFlags.n ^ selFlags.v;
            sparcPkg::condLeu:    condTrue = selFlags.c | selFlags.z;
            sparcPkg::condCs:     condTrue = selFlags.c;
            sparcPkg::condNeg:    condTrue = selFlags.n;
            sparcPkg::condVs:     condTrue = selFlags.v;
            sparcPkg::condAlways: condTrue = 1'b1;
            sparcPkg::condNe:     condTrue = ~selFlags.z;
            sparcPkg::condGt:     condTrue = ~(selFlags.z | (selFlags.n ^ selFlags.v));
            sparcPkg::condGe:     condTrue = ~(selFlags.n ^ selFlags.v);
            sparcPkg::condGu:     condTrue = ~(selFlags.c | selFlags.z);
            sparcPkg::condCc:     condTrue = ~selFlags.c;
            sparcPkg::condPos:    condTrue = ~selFlags.n;
            default:              condTrue = ~selFlags.v; // condVc
        endcase
    end

    assign taken = isBranch & condTrue;

endmodule

/* logic/programCounter.sv */
`timescale 1ns/10ps
`include "sparc_defines.svh"

module programCounter (
    input  logic           Clk,
    input  logic           reset,
    input  logic           load,
    input  sparcPkg::wordT target,
    output sparcPkg::wordT pc
);

    always_ff @(posedge Clk)
    begin
        if (reset)
            pc <= `RESET_PC;
        else if (load)
            pc <= target; // Taken branch
        else
            pc <= pc + `PC_STEP;
    end

endmodule

/* logic/sparcPipeline.sv */
`timescale 1ns/10ps

module sparcPipeline (
    input  logic              Clk,
    input  logic              reset,
    input  sparcPkg::wordT    instr,
    output sparcPkg::wordT    pc,
    output logic              wbValid,
    output sparcPkg::regAddrT wbReg,
    output sparcPkg::wordT    wbData
);

    sparcPkg::wordT    idInstr;   // IF/ID
    sparcPkg::wordT    idPc;
    sparcPkg::aluOpT   idAluOp;
    sparcPkg::regAddrT idRs1;
    sparcPkg::regAddrT idRs2;
    sparcPkg::regAddrT idRd;
    logic              idUseImm;
    sparcPkg::wordT    idImm;
    logic              idRegWrite;
    logic              idSetCc;
    logic              idIsBranch;
    logic              idAnnul;
    sparcPkg::condT    idCond;
    sparcPkg::wordT    idDisp;
    sparcPkg::wordT    fileA;
    sparcPkg::wordT    fileB;
    sparcPkg::fwdSelT  fwdA;
    sparcPkg::fwdSelT  fwdB;
    sparcPkg::wordT    idOperandA;
    sparcPkg::wordT    idOperandB;
    logic              branchTaken;
    logic              psrCarry;
    sparcPkg::wordT    branchTarget;
    sparcPkg::wordT    exOperandA; // ID/EX
    sparcPkg::wordT    exOperandB;
    sparcPkg::aluOpT   exAluOp;
    sparcPkg::regAddrT exRd;
    logic              exRegWrite;
    logic              exSetCc;
    sparcPkg::wordT    exResult;
    sparcPkg::flagsT   exFlags;

    // EX wins over WB since it is the younger result
    function automatic sparcPkg::fwdSelT pickSource(
        input sparcPkg::regAddrT src,
        input logic              exWrite,
        input sparcPkg::regAddrT exDest,
        input logic              wbWrite,
        input sparcPkg::regAddrT wbDest
    );
        if (exWrite && (exDest != '0) && (exDest == src))
            return sparcPkg::fromEx;
        else if (wbWrite && (wbDest != '0) && (wbDest == src))
            return sparcPkg::fromWb;
        else
            return sparcPkg::fromFile;
    endfunction

    function automatic sparcPkg::wordT selectOperand(
        input sparcPkg::fwdSelT sel,
        input sparcPkg::wordT   fileValue,
        input sparcPkg::wordT   exValue,
        input sparcPkg::wordT   wbValue
    );
        case (sel)
            sparcPkg::fromEx: return exValue;
            sparcPkg::fromWb: return wbValue;
            default:          return fileValue;
        endcase
    endfunction

    programCounter pcUnit (
        .Clk    (Clk),
        .reset  (reset),
        .load   (branchTaken),
        .target (branchTarget),
        .pc     (pc)
    );

    always_ff @(posedge Clk)
    begin
        if (reset)
            idInstr <= '0;
        else if (idIsBranch && idAnnul)
            idInstr <= '0;    // Delay slot squashed to a nop
        else
            idInstr <= instr;
        idPc <= pc;
    end

    instructionDecoder decoder (
        .instr    (idInstr),
        .aluOp    (idAluOp),
        .rs1      (idRs1),
        .rs2      (idRs2),
        .rd       (idRd),
        .useImm   (idUseImm),
        .immValue (idImm),
        .regWrite (idRegWrite),
        .setCc    (idSetCc),
        .isBranch (idIsBranch),
        .annul    (idAnnul),
        .cond     (idCond),
        .disp     (idDisp)
    );

    registerFile regFile (
        .Clk       (Clk),
        .readA     (idRs1),
        .readB     (idRs2),
        .dataA     (fileA),
        .dataB     (fileB),
        .writeEn   (wbValid),
        .writeAddr (wbReg),
        .writeData (wbData)
    );

    assign fwdA = pickSource(idRs1, exRegWrite, exRd, wbValid, wbReg);
    assign fwdB = pickSource(idRs2, exRegWrite, exRd, wbValid, wbReg);

    assign idOperandA = selectOperand(fwdA, fileA, exResult, wbData);
    assign idOperandB = idUseImm ? idImm : selectOperand(fwdB, fileB, exResult, wbData);

    // Target is relative to the branch itself, not the delay slot
    assign branchTarget = idPc + (idDisp << 2);

    branchCondition branchUnit (
        .Clk      (Clk),
        .reset    (reset),
        .exFlags  (exFlags),
        .exSetCc  (exSetCc),
        .cond     (idCond),
        .isBranch (idIsBranch),
        .carry    (psrCarry),
        .taken    (branchTaken)
    );

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            exRegWrite <= 1'b0;
            exSetCc    <= 1'b0;
        end
        else
        begin
            exRegWrite <= idRegWrite;
            exSetCc    <= idSetCc;
        end
        exOperandA <= idOperandA;
        exOperandB <= idOperandB;
        exAluOp    <= idAluOp;
        exRd       <= idRd;
    end

    alu aluUnit (
        .op      (exAluOp),
        .a       (exOperandA),
        .b       (exOperandB),
        .carryIn (psrCarry),
        .result  (exResult),
        .flags   (exFlags)
    );

    // EX/WB drives the write-back port directly
    always_ff @(posedge Clk)
    begin
        if (reset)
            wbValid <= 1'b0;
        else
            wbValid <= exRegWrite;
        wbReg  <= exRd;
        wbData <= exResult;
    end

endmodule

/* bench/programTable.svh */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// Each row gives name, instruction, write expected, rd, write-back data and pc after sampling
// Rows are the dynamic stream, so addresses jump where a branch is taken
task automatic loadProgram();
    // Immediate ALU ops and SETHI
    addRow("add imm", arithImm(6'h00, 5'd1, 5'd0, 13'd5), 1'b1, 5'd1, 32'h0000_0005, 32'h04);
    addRow("add neg imm", arithImm(6'h00, 5'd2, 5'd0, 13'h1FFD), 1'b1, 5'd2, 32'hFFFF_FFFD,
           32'h08);
    addRow("or imm", arithImm(6'h02, 5'd3, 5'd1, 13'h0A0), 1'b1, 5'd3, 32'h0000_00A5, 32'h0C);
    addRow("sethi", sethiWord(5'd4, 22'h012345), 1'b1, 5'd4, 32'h048D_1400, 32'h10);
    addRow("xor imm", arithImm(6'h03, 5'd5, 5'd3, 13'h0FF), 1'b1, 5'd5, 32'h0000_005A, 32'h14);
    addRow("sub imm", arithImm(6'h04, 5'd6, 5'd4, 13'h400), 1'b1, 5'd6, 32'h048D_1000, 32'h18);
    addRow("and imm", arithImm(6'h01, 5'd7, 5'd2, 13'h0F0), 1'b1, 5'd7, 32'h0000_00F0, 32'h1C);
    addRow("andn imm", arithImm(6'h05, 5'd8, 5'd2, 13'h00F), 1'b1, 5'd8, 32'hFFFF_FFF0, 32'h20);
    addRow("orn imm", arithImm(6'h06, 5'd9, 5'd0, 13'h00F), 1'b1, 5'd9, 32'hFFFF_FFF0, 32'h24);
    addRow("xnor imm", arithImm(6'h07, 5'd10, 5'd1, 13'h006), 1'b1, 5'd10, 32'hFFFF_FFFC, 32'h28);
    addRow("sll imm", arithImm(6'h25, 5'd11, 5'd1, 13'd4), 1'b1, 5'd11, 32'h0000_0050, 32'h2C);
    addRow("srl imm", arithImm(6'h26, 5'd12, 5'd2, 13'd28), 1'b1, 5'd12, 32'h0000_000F, 32'h30);
    addRow("sra imm", arithImm(6'h27, 5'd13, 5'd2, 13'd1), 1'b1, 5'd13, 32'hFFFF_FFFE, 32'h34);
    // Back-to-back register ops
    addRow("add reg", arithReg(6'h00, 5'd14, 5'd1, 5'd1), 1'b1, 5'd14, 32'h0000_000A, 32'h38);
    addRow("add fwd ex", arithReg(6'h00, 5'd15, 5'd14, 5'd1), 1'b1, 5'd15, 32'h0000_000F, 32'h3C);
    addRow("sub fwd ex wb", arithReg(6'h04, 5'd16, 5'd15, 5'd14), 1'b1, 5'd16, 32'h0000_0005,
           32'h40);
    addRow("add to r0", arithReg(6'h00, 5'd0, 5'd1, 5'd1), 1'b1, 5'd0, 32'h0000_000A, 32'h44);
    addRow("r0 behind ex", arithReg(6'h02, 5'd17, 5'd0, 5'd1), 1'b1, 5'd17, 32'h0000_0005, 32'h48);
    addRow("r0 behind wb", arithReg(6'h00, 5'd18, 5'd1, 5'd0), 1'b1, 5'd18, 32'h0000_0005, 32'h4C);
    // Condition codes and carry
    addRow("subcc zero", arithImm(6'h14, 5'd19, 5'd1, 13'd5), 1'b1, 5'd19, 32'h0, 32'h50);
    addRow("be taken", branchWord(1'b0, 4'h1, 22'd4), 1'b0, 5'd0, 32'h0, 32'h54);
    addRow("be slot", arithImm(6'h00, 5'd20, 5'd0, 13'd1), 1'b1, 5'd20, 32'h0000_0001, 32'h60);
    addRow("sethi max", sethiWord(5'd21, 22'h1FFFFF), 1'b1, 5'd21, 32'h7FFF_FC00, 32'h64);
    addRow("or low bits", arithImm(6'h02, 5'd21, 5'd21, 13'h3FF), 1'b1, 5'd21, 32'h7FFF_FFFF,
           32'h68);
    addRow("addcc overflow", arithImm(6'h10, 5'd22, 5'd21, 13'd1), 1'b1, 5'd22, 32'h8000_0000,
           32'h6C);
    addRow("bvs taken", branchWord(1'b0, 4'h7, 22'd8), 1'b0, 5'd0, 32'h0, 32'h70);
    addRow("bvs slot nop", 32'h0000_0000, 1'b0, 5'd0, 32'h0, 32'h8C);
    addRow("addcc carry", arithImm(6'h10, 5'd23, 5'd2, 13'd5), 1'b1, 5'd23, 32'h0000_0002, 32'h90);
    addRow("addx carry", arithImm(6'h08, 5'd24, 5'd0, 13'd0), 1'b1, 5'd24, 32'h0000_0001, 32'h94);
    // Branch pc rules with flags from the PSR
    addRow("subcc to psr", arithImm(6'h14, 5'd25, 5'd1, 13'd5), 1'b1, 5'd25, 32'h0, 32'h98);
    addRow("add no cc", arithImm(6'h00, 5'd0, 5'd1, 13'd0), 1'b1, 5'd0, 32'h0000_0005, 32'h9C);
    addRow("bne untaken", branchWord(1'b0, 4'h9, 22'd8), 1'b0, 5'd0, 32'h0, 32'hA0);
    addRow("bne slot", arithImm(6'h00, 5'd26, 5'd0, 13'd2), 1'b1, 5'd26, 32'h0000_0002, 32'hA4);
    addRow("ba backward", branchWord(1'b0, 4'h8, 22'h3FFFF7), 1'b0, 5'd0, 32'h0, 32'hA8);
    addRow("ba slot", arithImm(6'h00, 5'd27, 5'd26, 13'd3), 1'b1, 5'd27, 32'h0000_0005, 32'h80);
    addRow("bn untaken", branchWord(1'b0, 4'h0, 22'd100), 1'b0, 5'd0, 32'h0, 32'h84);
    addRow("bn slot", arithImm(6'h00, 5'd28, 5'd0, 13'd3), 1'b1, 5'd28, 32'h0000_0003, 32'h88);
    // Annul squashes the slot either way
    addRow("ba annul", branchWord(1'b1, 4'h8, 22'd16), 1'b0, 5'd0, 32'h0, 32'h8C);
    addRow("ba annulled slot", arithImm(6'h00, 5'd29, 5'd0, 13'd7), 1'b0, 5'd0, 32'h0, 32'hC8);
    addRow("bn annul", branchWord(1'b1, 4'h0, 22'd4), 1'b0, 5'd0, 32'h0, 32'hCC);
    addRow("bn annulled slot", arithImm(6'h00, 5'd30, 5'd0, 13'd8), 1'b0, 5'd0, 32'h0, 32'hD0);
    addRow("after annul", arithImm(6'h02, 5'd31, 5'd28, 13'h010), 1'b1, 5'd31, 32'h0000_0013,
           32'hD4);
    // Words that must not write
    addRow("nop", 32'h0000_0000, 1'b0, 5'd0, 32'h0, 32'hD8);
    addRow("call word", 32'h4000_0010, 1'b0, 5'd0, 32'h0, 32'hDC);
    addRow("memory word", 32'hC200_6004, 1'b0, 5'd0, 32'h0, 32'hE0);
    addRow("add after nops", arithReg(6'h00, 5'd5, 5'd31, 5'd31), 1'b1, 5'd5, 32'h0000_0026,
           32'hE4);
endtask

`endif

/* bench/sparcPipelineTb.sv */
`timescale 1ns/10ps

module sparcPipelineTb;

    typedef struct packed {
        sparcPkg::wordT    instr;
        logic              valid;  // Write-back expected
        sparcPkg::regAddrT rd;
        sparcPkg::wordT    data;
        sparcPkg::wordT    pc;     // pc one cycle after sampling
    } rowT;

    localparam int RESET_CYCLES = 4;
    localparam int PIPE_DEPTH   = 3; // Driving edge to write-back edge

    logic              Clk;
    logic              reset;
    sparcPkg::wordT    instr;
    sparcPkg::wordT    pc;
    logic              wbValid;
    sparcPkg::regAddrT wbReg;
    sparcPkg::wordT    wbData;

    rowT   rows[$];
    string rowNames[$];

    sparcPipeline uut (
        .Clk     (Clk),
        .reset   (reset),
        .instr   (instr),
        .pc      (pc),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

    always #10 Clk = ~Clk;

    // SPARC format 3 in immediate and register forms
    function automatic sparcPkg::wordT arithImm(input logic [5:0] op3,
        input sparcPkg::regAddrT rd, input sparcPkg::regAddrT rs1, input logic [12:0] simm);
        return {2'b10, rd, op3, rs1, 1'b1, simm};
    endfunction

    function automatic sparcPkg::wordT arithReg(input logic [5:0] op3,
        input sparcPkg::regAddrT rd, input sparcPkg::regAddrT rs1, input sparcPkg::regAddrT rs2);
        return {2'b10, rd, op3, rs1, 1'b0, 8'h00, rs2};
    endfunction

    function automatic sparcPkg::wordT sethiWord(input sparcPkg::regAddrT rd,
        input logic [21:0] imm22);
        return {2'b00, rd, 3'b100, imm22};
    endfunction

    function automatic sparcPkg::wordT branchWord(input logic annul, input logic [3:0] cond,
        input logic [21:0] disp22);
        return {2'b00, annul, cond, 3'b010, disp22};
    endfunction

    task automatic addRow(input string name, input sparcPkg::wordT word, input logic valid,
        input sparcPkg::regAddrT rd, input sparcPkg::wordT data, input sparcPkg::wordT nextPc);
        rowT row;
        row.instr = word;
        row.valid = valid;
        row.rd    = rd;
        row.data  = data;
        row.pc    = nextPc;
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    `include "programTable.svh"

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input sparcPkg::wordT expected,
        input sparcPkg::wordT actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkReg(input string name, input sparcPkg::regAddrT expected,
        input sparcPkg::regAddrT actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected r%0d, actual r%0d", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    // Write-back of row idx is due in this cycle
    task automatic checkWriteBack(input int idx);
        rowT row;
        row = rows[idx];
        checkBit({rowNames[idx], " wbValid"}, row.valid, wbValid);
        if (row.valid)
        begin
            checkReg({rowNames[idx], " wbReg"}, row.rd, wbReg);
            checkWord({rowNames[idx], " wbData"}, row.data, wbData);
        end
    endtask

    initial
    begin
        int k;
        Clk   = 1'b0;
        reset = 1'b1;
        instr = '0;
        loadProgram();
        for (k = 1; k < RESET_CYCLES; k++)
            @(posedge Clk);
        @(negedge Clk);
        checkWord("reset pc", 32'h0000_0000, pc);
        checkBit("reset wbValid", 1'b0, wbValid);
        // Row k is driven at edge k and sampled at edge k+1
        for (k = 0; k < rows.size() + PIPE_DEPTH; k++)
        begin
            @(posedge Clk);
            reset <= 1'b0;                // Last reset edge is k = 0
            instr <= (k < rows.size()) ? rows[k].instr : '0;
            @(negedge Clk);
            if ((k >= 1) && (k <= rows.size()))
                checkWord({rowNames[k-1], " pc"}, rows[k-1].pc, pc);
            if (k >= PIPE_DEPTH)
                checkWriteBack(k - PIPE_DEPTH);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
+incdir+bench
logic/sparcPkg.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/alu.sv
logic/branchCondition.sv
logic/programCounter.sv
logic/sparcPipeline.sv
bench/sparcPipelineTb.sv

/* run.sh */
#!/bin/sh
# Build and run the sparcPipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module sparcPipelineTb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VsparcPipelineTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
